// File: bch_dec.f
hdl/bch_pkg.sv
hdl/bch_syndrome.sv
hdl/bch_key.sv
hdl/bch_chien.sv
hdl/bch_dec_top.sv
test/tb_clk_gen.sv
test/bch_dec_chk.sv
test/bch_dec_tb.sv

// File: Makefile
.PHONY: all lint clean

all: obj_dir/Vbch_dec_tb
	./obj_dir/Vbch_dec_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

obj_dir/Vbch_dec_tb: bch_dec.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert --top-module bch_dec_tb -f bch_dec.f

lint:
	verilator --lint-only -Wall --top-module bch_dec_top \
		hdl/bch_pkg.sv \
		hdl/bch_syndrome.sv \
		hdl/bch_key.sv \
		hdl/bch_chien.sv \
		hdl/bch_dec_top.sv

clean:
	rm -rf obj_dir sim.log

// File: test/bch_dec_tb.sv
`timescale 1ns/1ps

module bch_dec_tb;

	localparam int timeout_cycles = 200;
	localparam int latency        = 32; // Start edge to out_valid edge.
	localparam int par_bits       = bch_pkg::n - bch_pkg::k;
	localparam logic [8:0] gen_poly = 9'h1d1; // x^8+x^7+x^6+x^4+1.

	logic                clk;
	logic                reset;
	logic                start;
	bch_pkg::word_t      codeword;
	logic                busy;
	logic                out_valid;
	bch_pkg::msg_t       data_out;
	bch_pkg::err_count_t err_count;
	logic                uncorrectable;

	integer seed;
	int     edge_cnt = 0;
	int     sent_edge = 0;
	int     last_out_edge = 0;
	int     checks = 0;
	int     errors = 0;     // Counted by the monitor.
	int     run_errors = 0; // Counted by the stimulus.
	int     results = 0;
	int     words = 0;
	int     tests = 0;
	int     test_base = 0;
	bit     timed_out = 0;

	bch_pkg::msg_t       exp_msg_q[$];
	bch_pkg::err_count_t exp_cnt_q[$];
	logic                exp_unc_q[$];

	tb_clk_gen i_tb_clk_gen (
		.clk   (clk),
		.reset (reset)
	);

	bch_dec_top i_bch_dec_top (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.codeword      (codeword),
		.busy          (busy),
		.out_valid     (out_valid),
		.data_out      (data_out),
		.err_count     (err_count),
		.uncorrectable (uncorrectable)
	);

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	// ----------------------------------------------------------------------
	// Reference model.
	// ----------------------------------------------------------------------
	function automatic bch_pkg::word_t encode(input bch_pkg::msg_t msg);
		bch_pkg::word_t r;
		int i;
		r = bch_pkg::word_t'(msg) << par_bits;
		for (i = bch_pkg::n - 1; i >= par_bits; i--)
			if (r[i])
				r = r ^ (bch_pkg::word_t'(gen_poly) << (i - par_bits));
		return {msg, r[par_bits-1:0]}; // Systematic, parity in the low bits.
	endfunction

	function automatic void ref_decode(input bch_pkg::word_t w, output bch_pkg::msg_t msg,
			output bch_pkg::err_count_t cnt, output logic unc);
		int c;
		int d;
		int best_d;
		bch_pkg::msg_t best_m;
		best_d = bch_pkg::n + 1;
		best_m = '0;
		for (c = 0; c < (1 << bch_pkg::k); c++) begin
			d = $countones(w ^ encode(bch_pkg::msg_t'(c)));
			if (d < best_d) begin
				best_d = d;
				best_m = bch_pkg::msg_t'(c);
			end
		end
		if (best_d <= bch_pkg::t) begin
			msg = best_m;
			cnt = bch_pkg::err_count_t'(best_d);
			unc = 1'b0;
		end else begin
			msg = w[bch_pkg::n-1 -: bch_pkg::k]; // Left as received.
			cnt = '1;
			unc = 1'b1;
		end
	endfunction

	// ----------------------------------------------------------------------
	// Compare tasks and monitor.
	// ----------------------------------------------------------------------
	task automatic check_msg(input bch_pkg::msg_t got, input bch_pkg::msg_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t: data_out is %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input bch_pkg::err_count_t got, input bch_pkg::err_count_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t: err_count is %0d, expected %0d", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t: uncorrectable is %b, expected %b", $time, got, exp);
			errors++;
		end
	endtask

	always @(negedge clk) begin
		if (!reset && out_valid) begin
			results++;
			last_out_edge = edge_cnt;
			if (exp_msg_q.size() == 0) begin
				$display("Result at %0t arrived with no word outstanding", $time);
				errors++;
			end else begin
				check_msg(data_out, exp_msg_q.pop_front());
				check_count(err_count, exp_cnt_q.pop_front());
				check_flag(uncorrectable, exp_unc_q.pop_front());
			end
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus.
	// ----------------------------------------------------------------------
	task automatic note_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		run_errors++;
		timed_out = 1'b1;
	endtask

	task automatic wait_reset();
		int i;
		i = 0;
		@(posedge clk);
		while (reset && i < timeout_cycles) begin
			@(posedge clk);
			i++;
		end
		if (reset)
			note_timeout("reset was never released");
	endtask

	task automatic drain();
		int i;
		i = 0;
		while (exp_msg_q.size() != 0 && i < timeout_cycles) begin
			@(posedge clk);
			i++;
		end
		if (exp_msg_q.size() != 0)
			note_timeout("results still outstanding");
	endtask

	task automatic send_word(input bch_pkg::word_t w);
		int i;
		bch_pkg::msg_t m;
		bch_pkg::err_count_t c;
		logic u;
		i = 0;
		@(posedge clk);
		while (busy && i < timeout_cycles) begin
			@(posedge clk);
			i++;
		end
		if (busy) begin
			note_timeout("busy stayed high");
		end else begin
			ref_decode(w, m, c, u);
			exp_msg_q.push_back(m);
			exp_cnt_q.push_back(c);
			exp_unc_q.push_back(u);
			sent_edge = edge_cnt + 2; // Edge that samples start.
			start    <= 1'b1;
			codeword <= w;
			words++;
			@(posedge clk);
			start <= 1'b0;
		end
	endtask

	task automatic make_errors(input int nerr, output bch_pkg::word_t mask);
		int pos;
		mask = '0;
		while ($countones(mask) < nerr) begin
			pos = {$random(seed)} % bch_pkg::n;
			mask[pos] = 1'b1;
		end
	endtask

	task automatic run_clean();
		bch_pkg::msg_t msg;
		msg = bch_pkg::msg_t'($random(seed));
		@(negedge clk);
		if (busy !== 1'b0 || out_valid !== 1'b0) begin
			$display("FAIL %0t: busy or out_valid not low after reset", $time);
			run_errors++;
		end
		send_word(encode(msg));
		drain();
		if (!timed_out && last_out_edge - sent_edge != latency) begin
			$display("FAIL %0t: latency %0d cycles, expected %0d", $time,
				last_out_edge - sent_edge, latency);
			run_errors++;
		end
	endtask

	task automatic run_single();
		int pos;
		bch_pkg::msg_t msg;
		for (pos = 0; pos < bch_pkg::n && !timed_out; pos++) begin
			msg = bch_pkg::msg_t'($random(seed));
			send_word(encode(msg) ^ (bch_pkg::word_t'(1) << pos));
		end
		drain();
	endtask

	// Error count drawn from nerr_min up to nerr_max for each word.
	task automatic run_random(input int nerr_min, input int nerr_max, input int count);
		int i;
		int nerr;
		bch_pkg::msg_t msg;
		bch_pkg::word_t mask;
		for (i = 0; i < count && !timed_out; i++) begin
			nerr = nerr_min + {$random(seed)} % (nerr_max - nerr_min + 1);
			msg = bch_pkg::msg_t'($random(seed));
			make_errors(nerr, mask);
			send_word(encode(msg) ^ mask);
		end
		drain();
	endtask

	task automatic report_test(input string name);
		int bad;
		bad = errors + run_errors - test_base;
		tests++;
		$display("test %0d, %s: %0d errors", tests, name, bad);
		test_base = errors + run_errors;
	endtask

	initial begin
		int total;
		start    <= 1'b0;
		codeword <= '0;
		seed = 32'h1740_8457;
		wait_reset();
		if (!timed_out) begin
			run_clean();
			report_test("reset and clean word");
		end
		if (!timed_out) begin
			run_single();
			report_test("single error at each position");
		end
		if (!timed_out) begin
			run_random(2, 2, 40);
			report_test("random double errors");
		end
		if (!timed_out) begin
			run_random(3, 3, 40);
			report_test("triple errors");
		end
		if (!timed_out) begin
			run_random(0, 3, 200);
			report_test("back-to-back random words");
		end
		total = errors + run_errors + i_bch_dec_top.i_bch_dec_chk.fails;
		$display("%0d tests, %0d words, %0d results, %0d checks, %0d errors",
			tests, words, results, checks, total);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: test/bch_dec_chk.sv
`timescale 1ns/1ps

module bch_dec_chk (
	input logic                clk,
	input logic                reset,
	input logic                start,
	input logic                busy,
	input logic                chien_accepted,
	input bch_pkg::err_count_t key_count,
	input logic                out_valid,
	input bch_pkg::err_count_t err_count,
	input logic                uncorrectable
);
	int fails = 0; // Read by the testbench at the end.

	bch_pkg::err_count_t taken_count; // Count handed to the Chien stage.

	always_ff @(posedge clk)
		if (chien_accepted)
			taken_count <= key_count;

	// A new word only while the syndrome stage is free.
	start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
		else begin
			$error("start while busy");
			fails++;
		end

	valid_pulse: assert property (@(posedge clk) disable iff (reset) out_valid |=> !out_valid)
		else begin
			$error("out_valid longer than one cycle");
			fails++;
		end

	// A count of 3 from the key stage comes out flagged.
	// Any other count passes through unless the roots disagree.
	unc_count: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (taken_count == '1 ? uncorrectable
			: (uncorrectable || err_count == taken_count)))
		else begin
			$error("uncorrectable does not match the key stage count");
			fails++;
		end

	quiet_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else begin
			$error("out_valid during reset");
			fails++;
		end

endmodule

bind bch_dec_top bch_dec_chk i_bch_dec_chk (
	.clk            (clk),
	.reset          (reset),
	.start          (start),
	.busy           (busy),
	.chien_accepted (chien_accepted),
	.key_count      (key_err_count),
	.out_valid      (out_valid),
	.err_count      (err_count),
	.uncorrectable  (uncorrectable)
);

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic reset
);
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period.
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: hdl/bch_dec_top.sv
`timescale 1ns/1ps

module bch_dec_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  bch_pkg::word_t       codeword,
	output logic                 busy,
	output logic                 out_valid,
	output bch_pkg::msg_t        data_out,
	output bch_pkg::err_count_t  err_count,
	output logic                 uncorrectable
);
	// Syndrome to key.
	logic                syn_start;
	logic                key_accepted;
	bch_pkg::gf_t        s1;
	bch_pkg::gf_t        s3;
	bch_pkg::word_t      word_hold;

	// Key to Chien.
	logic                key_done;
	logic                chien_accepted;
	bch_pkg::gf_t        sigma0;
	bch_pkg::gf_t        sigma1;
	bch_pkg::gf_t        sigma2;
	bch_pkg::err_count_t key_err_count;

	bch_syndrome i_bch_syndrome (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.codeword     (codeword),
		.key_accepted (key_accepted),
		.busy         (busy),
		.syn_start    (syn_start),
		.s1           (s1),
		.s3           (s3),
		.word_hold    (word_hold)
	);

	bch_key i_bch_key (
		.clk            (clk),
		.reset          (reset),
		.syn_start      (syn_start),
		.s1             (s1),
		.s3             (s3),
		.chien_accepted (chien_accepted),
		.key_accepted   (key_accepted),
		.sigma0         (sigma0),
		.sigma1         (sigma1),
		.sigma2         (sigma2),
		.err_count      (key_err_count),
		.key_done       (key_done),
		.busy           ()          // Used inside the key stage only.
	);

	bch_chien i_bch_chien (
		.clk            (clk),
		.reset          (reset),
		.key_done       (key_done),
		.sigma0         (sigma0),
		.sigma1         (sigma1),
		.sigma2         (sigma2),
		.err_count      (key_err_count),
		.word_hold      (word_hold),
		.chien_accepted (chien_accepted),
		.out_valid      (out_valid),
		.data_out       (data_out),
		.err_count_out  (err_count),
		.uncorrectable  (uncorrectable)
	);

endmodule

// File: hdl/bch_chien.sv
`timescale 1ns/1ps

module bch_chien (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 key_done,
	input  bch_pkg::gf_t         sigma0,
	input  bch_pkg::gf_t         sigma1,
	input  bch_pkg::gf_t         sigma2,
	input  bch_pkg::err_count_t  err_count,
	input  bch_pkg::word_t       word_hold,
	output logic                 chien_accepted,
	output logic                 out_valid,
	output bch_pkg::msg_t        data_out,
	output bch_pkg::err_count_t  err_count_out,
	output logic                 uncorrectable
);
	// alpha^-1 = alpha^14 = alpha^3 + 1.
	localparam bch_pkg::gf_t alpha_inv  = bch_pkg::alpha3_step ^ bch_pkg::gf_t'(1);
	localparam bch_pkg::gf_t alpha_inv2 = bch_pkg::gf_mul(alpha_inv, alpha_inv);

	logic                running;
	logic                pending;   // Key result waiting for us.
	logic [3:0]          cnt;       // Position under test.
	logic                last;
	logic                fix_en;
	logic                root;
	logic                fail;
	bch_pkg::gf_t        t0;
	bch_pkg::gf_t        t1;
	bch_pkg::gf_t        t2;
	bch_pkg::gf_t        locator;
	bch_pkg::err_count_t cnt_in;
	bch_pkg::err_count_t roots;
	bch_pkg::err_count_t roots_next;
	bch_pkg::word_t      word_sh;
	bch_pkg::word_t      word_next;
	bch_pkg::msg_t       msg_raw;

	assign chien_accepted = (key_done || pending) && !running;

	assign last    = cnt == 4'(bch_pkg::n - 1);
	assign locator = t0 ^ t1 ^ t2;
	assign fix_en  = cnt_in == 2'd1 || cnt_in == 2'd2; // Zero locator otherwise.
	assign root    = running && fix_en && locator == '0;

	// Rotate right, bit 0 is the position under test.
	assign word_next  = {word_sh[0] ^ root, word_sh[bch_pkg::n-1:1]};
	assign roots_next = roots + bch_pkg::err_count_t'(root);
	assign fail       = cnt_in == '1 || (cnt_in != '0 && roots_next != cnt_in);

	// ----------------------------------------------------------------------
	// Control.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			running   <= 1'b0;
			pending   <= 1'b0;
			cnt       <= '0;
			out_valid <= 1'b0;
		end else begin
			pending   <= (key_done || pending) && !chien_accepted;
			out_valid <= 1'b0;
			if (chien_accepted) begin
				running <= 1'b1;
				cnt     <= '0;
			end else if (running) begin
				cnt <= cnt + 4'd1;
				if (last) begin
					running   <= 1'b0;
					out_valid <= 1'b1;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Search, one position per cycle from 0 up to 14.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (chien_accepted) begin
			t0      <= sigma0;
			t1      <= sigma1;
			t2      <= sigma2;
			cnt_in  <= err_count;
			roots   <= '0;
			word_sh <= word_hold;
			msg_raw <= word_hold[bch_pkg::n-1 -: bch_pkg::k];
		end else if (running) begin
			t1      <= bch_pkg::gf_mul(t1, alpha_inv);
			t2      <= bch_pkg::gf_mul(t2, alpha_inv2);
			roots   <= roots_next;
			word_sh <= word_next;
		end
		if (running && last) begin
			uncorrectable <= fail;
			if (fail) begin
				err_count_out <= '1;
				data_out      <= msg_raw; // Word left as received.
			end else begin
				err_count_out <= cnt_in;
				data_out      <= word_next[bch_pkg::n-1 -: bch_pkg::k];
			end
		end
	end

endmodule

// File: hdl/bch_key.sv
`timescale 1ns/1ps

module bch_key (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  syn_start,
	input  bch_pkg::gf_t          s1,
	input  bch_pkg::gf_t          s3,
	input  logic                  chien_accepted,
	output logic                  key_accepted,
	output bch_pkg::gf_t          sigma0,
	output bch_pkg::gf_t          sigma1,
	output bch_pkg::gf_t          sigma2,
	output bch_pkg::err_count_t   err_count,
	output logic                  key_done,
	output logic                  busy
);
	logic         waiting;
	bch_pkg::gf_t s1_cube;
	logic         s1_zero;
	logic         s3_zero;
	logic         single;

	assign s1_cube = bch_pkg::gf_cube(s1);
	assign s1_zero = s1 == '0;
	assign s3_zero = s3 == '0;
	assign single  = s3 == s1_cube;

	// Result is held from key_done until the Chien stage takes it.
	assign busy         = (key_done || waiting) && !chien_accepted;
	assign key_accepted = syn_start && !busy;

	// ----------------------------------------------------------------------
	// Handshake.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			key_done <= 1'b0;
			waiting  <= 1'b0;
		end else begin
			key_done <= key_accepted;
			if (key_done && !chien_accepted)
				waiting <= 1'b1;
			else if (chien_accepted)
				waiting <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Direct t=2 solution, locator scaled by S1.
	//   sigma(x) = S1 + S1^2 x + (S3 + S1^3) x^2
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (key_accepted) begin
			sigma0 <= s1;
			sigma1 <= bch_pkg::gf_mul(s1, s1);
			sigma2 <= s3 ^ s1_cube; // Zero for a single error.
			if (!s1_zero) begin
				if (single)
					err_count <= 2'd1;
				else
					err_count <= 2'd2;
			end else if (!s3_zero) begin
				err_count <= '1; // Cannot be corrected.
			end else begin
				err_count <= '0;
			end
		end
	end

endmodule

// File: hdl/bch_syndrome.sv
`timescale 1ns/1ps

module bch_syndrome (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  bch_pkg::word_t  codeword,
	input  logic            key_accepted,
	output logic            busy,
	output logic            syn_start,
	output bch_pkg::gf_t    s1,
	output bch_pkg::gf_t    s3,
	output bch_pkg::word_t  word_hold
);
	localparam bch_pkg::gf_t alpha_step = 4'b0010;

	logic           running;
	logic [3:0]     cnt;       // Horner steps done.
	logic           load;
	logic           step;
	logic           xfer;
	logic           in_bit;
	bch_pkg::word_t shreg;
	bch_pkg::word_t word_buf;  // Pairs with s1/s3 in the hold stage.
	bch_pkg::gf_t   s1_acc;
	bch_pkg::gf_t   s3_acc;
	bch_pkg::gf_t   s1_base;
	bch_pkg::gf_t   s3_base;

	assign load = start && !running;
	assign step = running && cnt != 4'(bch_pkg::n);
	// Stall here while the hold stage is still full.
	assign xfer = running && cnt == 4'(bch_pkg::n) && (!syn_start || key_accepted);
	assign busy = running;

	// The first step happens in the start cycle itself.
	assign in_bit  = load ? codeword[bch_pkg::n-1] : shreg[bch_pkg::n-1];
	assign s1_base = load ? bch_pkg::gf_t'(0) : s1_acc;
	assign s3_base = load ? bch_pkg::gf_t'(0) : s3_acc;

	// ----------------------------------------------------------------------
	// Control.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			running   <= 1'b0;
			cnt       <= '0;
			syn_start <= 1'b0;
		end else begin
			if (load) begin
				running <= 1'b1;
				cnt     <= 4'd1;
			end else if (step) begin
				cnt <= cnt + 4'd1;
			end else if (xfer) begin
				running <= 1'b0;
			end
			if (xfer)
				syn_start <= 1'b1;
			else if (key_accepted)
				syn_start <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Horner evaluation at alpha and alpha^3, then hold.
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load)
			shreg <= {codeword[bch_pkg::n-2:0], codeword[bch_pkg::n-1]};
		else if (step)
			shreg <= {shreg[bch_pkg::n-2:0], shreg[bch_pkg::n-1]}; // Back in order after 15.
		if (load || step) begin
			s1_acc <= bch_pkg::gf_mul(s1_base, alpha_step) ^ bch_pkg::gf_t'(in_bit);
			s3_acc <= bch_pkg::gf_mul(s3_base, bch_pkg::alpha3_step) ^ bch_pkg::gf_t'(in_bit);
		end
		if (xfer) begin
			s1       <= s1_acc;
			s3       <= s3_acc;
			word_buf <= shreg;
		end
		if (key_accepted)
			word_hold <= word_buf; // Follows the key result.
	end

endmodule

// File: hdl/bch_pkg.sv
package bch_pkg;

	// ----------------------------------------------------------------------
	// (15,7) binary BCH code over GF(2^4), two-error correcting.
	// ----------------------------------------------------------------------
	localparam int m = 4;  // Field width.
	localparam int n = 15; // Code length.
	localparam int k = 7;  // Message length.
	localparam int t = 2;  // Correctable errors.

	typedef logic [m-1:0] gf_t;
	typedef logic [n-1:0] word_t;            // Bit 14 is sent first.
	typedef logic [k-1:0] msg_t;             // Top bits of a systematic word.
	typedef logic [$clog2(t + 2)-1:0] err_count_t; // All ones is uncorrectable.

	// Low terms of x^4+x+1, since x^4 = x + 1.
	localparam gf_t prim_low = 4'b0011;

	localparam gf_t alpha3_step = 4'b1000; // alpha^3.

	// ----------------------------------------------------------------------
	// Field arithmetic.
	// ----------------------------------------------------------------------
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t p;
		int i;
		p = '0;
		for (i = m - 1; i >= 0; i--) begin
			// Shift up one power and reduce.
			p = {p[m-2:0], 1'b0} ^ (p[m-1] ? prim_low : gf_t'(0));
			if (b[i])
				p = p ^ a;
		end
		return p;
	endfunction

	function automatic gf_t gf_cube(gf_t a);
		gf_t sq;
		sq = gf_mul(a, a);
		return gf_mul(sq, a);
	endfunction

endpackage
